//--- common/mcu_pkg.sv
//--------------------------------------------------------------------
// MCU peripheral package
// Shared word types, peripheral indices and register offsets
//--------------------------------------------------------------------
package mcu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [7:0]  byte_t;
  // Bits 5:3 peripheral index, bit 2 reserved, bits 1:0 register offset
  typedef logic [5:0]  bus_addr_t;
  typedef logic [1:0]  reg_off_t;
  // UART receive-full in bits 2:0, timers in bits 4:3
  typedef logic [4:0]  irq_vec_t;

  localparam int NUM_PERIPH = 7;
  localparam int NUM_UART   = 3;
  localparam int NUM_TIMER  = 2;

  // Peripheral indices on the bus
  localparam int IDX_GPIO0  = 0;
  localparam int IDX_GPIO1  = 1;
  localparam int IDX_UART0  = 2;
  localparam int IDX_UART1  = 3;
  localparam int IDX_UART2  = 4;
  localparam int IDX_TIMER0 = 5;
  localparam int IDX_TIMER1 = 6;

  // Interrupt vector positions
  localparam int IRQ_UART0  = 0;
  localparam int IRQ_TIMER0 = 3;

  // GPIO registers
  localparam reg_off_t GPIO_DATA    = 2'd0;
  localparam reg_off_t GPIO_DOUT    = 2'd1;
  localparam reg_off_t GPIO_OUTEN   = 2'd2;
  localparam reg_off_t GPIO_ALTFUNC = 2'd3;

  // UART registers
  localparam reg_off_t UART_DATA    = 2'd0;
  localparam reg_off_t UART_STATUS  = 2'd1;
  localparam reg_off_t UART_BAUDDIV = 2'd2;
  localparam reg_off_t UART_CTRL    = 2'd3;
  // Divider after reset, cycles per bit
  localparam word_t    UART_DIV_RST = 16'd16;

  // Timer registers
  localparam reg_off_t TMR_VALUE    = 2'd0;
  localparam reg_off_t TMR_RELOAD   = 2'd1;
  localparam reg_off_t TMR_CTRL     = 2'd2;
  localparam reg_off_t TMR_INT      = 2'd3;

endpackage

//--- common/periph_bus_if.sv
//--------------------------------------------------------------------
// Peripheral register bus
// Broadcast from the bus controller to every peripheral
//--------------------------------------------------------------------
`timescale 1ns/1ps

interface periph_bus_if;

  // Access strobes, qualified per peripheral by its select
  logic              wr;
  logic              rd;
  // Register offset and write data
  mcu_pkg::reg_off_t off;
  mcu_pkg::word_t    wdata;

  modport ctrl (
    output wr,
    output rd,
    output off,
    output wdata
  );

  modport periph (
    input wr,
    input rd,
    input off,
    input wdata
  );

endinterface

//--- rtl/periph_ctrl.sv
//--------------------------------------------------------------------
// Peripheral bus controller
// Decodes the register bus into peripheral selects, registers the
// read data with a valid pulse and registers the interrupt vector
//--------------------------------------------------------------------
`timescale 1ns/1ps

module periph_ctrl (
  input  logic                       i_hclk,
  input  logic                       i_reset,
  // Register bus from the top level
  input  mcu_pkg::bus_addr_t         i_bus_addr,
  input  mcu_pkg::word_t             i_bus_wdata,
  input  logic                       i_bus_wr,
  input  logic                       i_bus_rd,
  output mcu_pkg::word_t             o_bus_rdata,
  output logic                       o_bus_rvalid,
  // Peripheral side
  output logic [mcu_pkg::NUM_PERIPH-1:0] o_sel,
  input  mcu_pkg::word_t             i_rdata [mcu_pkg::NUM_PERIPH],
  input  mcu_pkg::irq_vec_t          i_irq_lvl,
  output mcu_pkg::irq_vec_t          o_irq,
  periph_bus_if.ctrl                 bus
);

  logic [2:0]     periph_idx;
  mcu_pkg::word_t sel_rdata;

  // Index in the upper bits, bit 2 reserved
  assign periph_idx = i_bus_addr[5:3];

  // Strobes, offset and data go to every peripheral
  assign bus.wr    = i_bus_wr;
  assign bus.rd    = i_bus_rd;
  assign bus.off   = i_bus_addr[1:0];
  assign bus.wdata = i_bus_wdata;

  //------------------------------------------------------------------
  // One-hot select and read return mux
  //------------------------------------------------------------------
  always_comb begin
    o_sel     = '0;
    sel_rdata = '0;
    for (int k = 0; k < mcu_pkg::NUM_PERIPH; k++) begin
      // Index 7 selects nothing and reads zero
      o_sel[k] = (int'(periph_idx) == k);
      if (o_sel[k]) begin
        sel_rdata = sel_rdata | i_rdata[k];
      end
    end
  end

  // Read word captured at the strobe edge
  always_ff @(posedge i_hclk) begin
    if (i_bus_rd) begin
      o_bus_rdata <= sel_rdata;
    end
  end

  // Valid pulse one cycle after the strobe, registered interrupts
  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      o_bus_rvalid <= 1'b0;
      o_irq        <= '0;
    end else begin
      o_bus_rvalid <= i_bus_rd;
      o_irq        <= i_irq_lvl;
    end
  end

endmodule

//--- rtl/gpio_port.sv
//--------------------------------------------------------------------
// GPIO port
// Data-out, output-enable and alternate-function registers with a
// two-flop synchronized pin input
//--------------------------------------------------------------------
`timescale 1ns/1ps

module gpio_port (
  input  logic           i_hclk,
  input  logic           i_reset,
  input  logic           i_sel,
  periph_bus_if.periph   bus,
  output mcu_pkg::word_t o_rdata,
  input  mcu_pkg::word_t i_pins,
  output mcu_pkg::word_t o_dout,
  output mcu_pkg::word_t o_outen,
  output mcu_pkg::word_t o_altfunc
);

  mcu_pkg::word_t pin_meta;
  mcu_pkg::word_t pin_sync;

  // Register writes
  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      o_dout    <= '0;
      o_outen   <= '0;
      o_altfunc <= '0;
    end else if (i_sel && bus.wr) begin
      case (bus.off)
        mcu_pkg::GPIO_DOUT:    o_dout    <= bus.wdata;
        mcu_pkg::GPIO_OUTEN:   o_outen   <= bus.wdata;
        mcu_pkg::GPIO_ALTFUNC: o_altfunc <= bus.wdata;
        // DATA is read only
        default: ;
      endcase
    end
  end

  // Pin synchronizer, two stages
  always_ff @(posedge i_hclk) begin
    pin_meta <= i_pins;
    pin_sync <= pin_meta;
  end

  // Read mux
  always_comb begin
    case (bus.off)
      mcu_pkg::GPIO_DATA:  o_rdata = pin_sync;
      mcu_pkg::GPIO_DOUT:  o_rdata = o_dout;
      mcu_pkg::GPIO_OUTEN: o_rdata = o_outen;
      default:             o_rdata = o_altfunc;
    endcase
  end

endmodule

//--- uart/uart.sv
//--------------------------------------------------------------------
// UART, 8N1 and LSB first
// Programmable baud divider, transmit shifter and mid-bit receive
// sampler with a receive-full flag as interrupt
//--------------------------------------------------------------------
`timescale 1ns/1ps

module uart (
  input  logic           i_hclk,
  input  logic           i_reset,
  input  logic           i_sel,
  periph_bus_if.periph   bus,
  output mcu_pkg::word_t o_rdata,
  input  logic           i_rxd,
  output logic           o_txd,
  output logic           o_txen,
  output logic           o_irq
);

  mcu_pkg::word_t baud_div;
  logic [1:0]     ctrl_q;
  logic           wr_en;
  logic           tx_start;
  logic           rd_clr;

  // Transmit state
  logic           tx_busy;
  logic [9:0]     tx_shift;
  mcu_pkg::word_t tx_cnt;
  logic [3:0]     tx_left;
  mcu_pkg::byte_t tx_byte;

  // Receive state
  logic [1:0]     rx_sync;
  logic           rxd_s;
  logic           rx_busy;
  logic           rx_full;
  mcu_pkg::word_t rx_cnt;
  logic [3:0]     rx_bit;
  logic           rx_sample;
  mcu_pkg::byte_t rx_shift;
  mcu_pkg::byte_t rx_data;

  assign wr_en   = i_sel & bus.wr;
  assign tx_byte = bus.wdata[7:0];
  // Byte accepted only while idle and enabled
  assign tx_start = wr_en && (bus.off == mcu_pkg::UART_DATA) && !tx_busy && ctrl_q[0];
  // Data read drops receive-full
  assign rd_clr = i_sel && bus.rd && (bus.off == mcu_pkg::UART_DATA);

  assign rxd_s     = rx_sync[1];
  assign rx_sample = rx_busy && (rx_cnt == '0);

  assign o_txd  = tx_shift[0];
  assign o_txen = ctrl_q[0];
  assign o_irq  = rx_full;

  //------------------------------------------------------------------
  // Control registers
  //------------------------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      baud_div <= mcu_pkg::UART_DIV_RST;
      ctrl_q   <= '0;
    end else if (wr_en) begin
      // Divider below 4 is not supported
      if (bus.off == mcu_pkg::UART_BAUDDIV) baud_div <= bus.wdata;
      if (bus.off == mcu_pkg::UART_CTRL)    ctrl_q   <= bus.wdata[1:0];
    end
  end

  //------------------------------------------------------------------
  // Transmitter
  //------------------------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      tx_busy  <= 1'b0;
      tx_shift <= '1;
      tx_cnt   <= '0;
      tx_left  <= '0;
    end else if (tx_start) begin
      tx_busy  <= 1'b1;
      // Stop, data, start
      tx_shift <= {1'b1, tx_byte, 1'b0};
      tx_cnt   <= baud_div - 16'd1;
      tx_left  <= 4'd10;
    end else if (tx_busy) begin
      if (tx_cnt == '0) begin
        // Shift in ones so the line idles high
        tx_shift <= {1'b1, tx_shift[9:1]};
        tx_cnt   <= baud_div - 16'd1;
        tx_left  <= tx_left - 4'd1;
        if (tx_left == 4'd1) begin
          tx_busy <= 1'b0;
        end
      end else begin
        tx_cnt <= tx_cnt - 16'd1;
      end
    end
  end

  //------------------------------------------------------------------
  // Receiver
  //------------------------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      rx_sync <= 2'b11;
      rx_busy <= 1'b0;
      rx_full <= 1'b0;
      rx_cnt  <= '0;
      rx_bit  <= '0;
    end else begin
      rx_sync <= {rx_sync[0], i_rxd};
      if (rd_clr) begin
        rx_full <= 1'b0;
      end
      if (!rx_busy) begin
        // Falling edge of the start bit, first sample half a bit on
        if (ctrl_q[1] && !rxd_s) begin
          rx_busy <= 1'b1;
          rx_cnt  <= {1'b0, baud_div[15:1]};
          rx_bit  <= '0;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 16'd1;
      end else begin
        rx_cnt <= baud_div - 16'd1;
        rx_bit <= rx_bit + 4'd1;
        // Glitch on the start bit aborts
        if (rx_bit == 4'd0 && rxd_s) begin
          rx_busy <= 1'b0;
        end
        if (rx_bit == 4'd9) begin
          rx_busy <= 1'b0;
          // Valid stop bit, new byte wins over a clear
          if (rxd_s) rx_full <= 1'b1;
        end
      end
    end
  end

  // Receive data path
  always_ff @(posedge i_hclk) begin
    if (rx_sample) begin
      if (rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
        rx_shift <= {rxd_s, rx_shift[7:1]};
      end
      if (rx_bit == 4'd9 && rxd_s) begin
        rx_data <= rx_shift;
      end
    end
  end

  // Read mux
  always_comb begin
    case (bus.off)
      mcu_pkg::UART_DATA:    o_rdata = {8'd0, rx_data};
      mcu_pkg::UART_STATUS:  o_rdata = {14'd0, rx_full, tx_busy};
      mcu_pkg::UART_BAUDDIV: o_rdata = baud_div;
      default:               o_rdata = {14'd0, ctrl_q};
    endcase
  end

endmodule

//--- rtl/io_timer.sv
//--------------------------------------------------------------------
// Down-counting timer
// Reload at zero with interrupt flag, optional gating by a
// synchronized external input
//--------------------------------------------------------------------
`timescale 1ns/1ps

module io_timer (
  input  logic           i_hclk,
  input  logic           i_reset,
  input  logic           i_sel,
  periph_bus_if.periph   bus,
  output mcu_pkg::word_t o_rdata,
  input  logic           i_extin,
  output logic           o_irq
);

  mcu_pkg::word_t value;
  mcu_pkg::word_t reload;
  // Bit 0 enable, bit 1 external gate, bit 2 interrupt enable
  logic [2:0]     ctrl_q;
  logic           int_flag;
  logic [1:0]     ext_sync;
  logic           wr_en;
  logic           tick;

  assign wr_en = i_sel & bus.wr;
  // Count cycle when enabled and not held by the gate
  assign tick  = ctrl_q[0] && (!ctrl_q[1] || ext_sync[1]);
  assign o_irq = int_flag & ctrl_q[2];

  always_ff @(posedge i_hclk) begin
    if (i_reset) begin
      value    <= '0;
      reload   <= '0;
      ctrl_q   <= '0;
      int_flag <= 1'b0;
      ext_sync <= '0;
    end else begin
      ext_sync <= {ext_sync[0], i_extin};
      if (wr_en && bus.off == mcu_pkg::TMR_RELOAD) reload <= bus.wdata;
      if (wr_en && bus.off == mcu_pkg::TMR_CTRL)   ctrl_q <= bus.wdata[2:0];
      // Write one to clear
      if (wr_en && bus.off == mcu_pkg::TMR_INT && bus.wdata[0]) int_flag <= 1'b0;

      // Software write overrides the count
      if (wr_en && bus.off == mcu_pkg::TMR_VALUE) begin
        value <= bus.wdata;
      end else if (tick) begin
        if (value == '0) begin
          value    <= reload;
          int_flag <= 1'b1;
        end else begin
          value <= value - 16'd1;
        end
      end
    end
  end

  // Read mux
  always_comb begin
    case (bus.off)
      mcu_pkg::TMR_VALUE:  o_rdata = value;
      mcu_pkg::TMR_RELOAD: o_rdata = reload;
      mcu_pkg::TMR_CTRL:   o_rdata = {13'd0, ctrl_q};
      default:             o_rdata = {15'd0, int_flag};
    endcase
  end

endmodule

//--- rtl/pin_mux.sv
//--------------------------------------------------------------------
// Pin multiplexer
// Routes UART and timer signals onto port 1 alternate-function pins
//--------------------------------------------------------------------
`timescale 1ns/1ps

module pin_mux (
  // GPIO register outputs
  input  mcu_pkg::word_t i_p0_dout,
  input  mcu_pkg::word_t i_p0_outen,
  input  mcu_pkg::word_t i_p1_dout,
  input  mcu_pkg::word_t i_p1_outen,
  input  mcu_pkg::word_t i_p1_altfunc,
  // Port 1 pad input
  input  mcu_pkg::word_t i_pad_p1,
  // Pad drivers
  output mcu_pkg::word_t o_p0_pad_out,
  output mcu_pkg::word_t o_p0_pad_oe,
  output mcu_pkg::word_t o_p1_pad_out,
  output mcu_pkg::word_t o_p1_pad_oe,
  output mcu_pkg::word_t o_p1_in,
  // Peripheral side
  input  logic [mcu_pkg::NUM_UART-1:0]  i_uart_txd,
  input  logic [mcu_pkg::NUM_UART-1:0]  i_uart_txen,
  output logic [mcu_pkg::NUM_UART-1:0]  o_uart_rxd,
  output logic [mcu_pkg::NUM_TIMER-1:0] o_timer_extin
);

  // Port 0 has no alternate functions
  assign o_p0_pad_out = i_p0_dout;
  assign o_p0_pad_oe  = i_p0_outen;

  // GPIO1 sees the raw pads
  assign o_p1_in = i_pad_p1;

  // Timer external inputs on pins 8 and 9
  assign o_timer_extin = i_pad_p1[9:8];

  //------------------------------------------------------------------
  // UART k uses pin 2k for receive, pin 2k+1 for transmit
  //------------------------------------------------------------------
  always_comb begin
    o_p1_pad_out = i_p1_dout;
    o_p1_pad_oe  = i_p1_outen;
    for (int k = 0; k < mcu_pkg::NUM_UART; k++) begin
      o_uart_rxd[k] = i_pad_p1[2*k];
      // Only when the pin's alternate-function bit is set
      if (i_p1_altfunc[2*k+1]) begin
        o_p1_pad_out[2*k+1] = i_uart_txd[k];
        o_p1_pad_oe[2*k+1]  = i_uart_txen[k];
      end
    end
  end

endmodule

//--- rtl/mcu_periph_top.sv
//--------------------------------------------------------------------
// MCU peripheral subsystem top level
// Bus controller, two GPIO ports, three UARTs, two timers, pin mux
//--------------------------------------------------------------------
`timescale 1ns/1ps

module mcu_periph_top (
  input  logic               i_hclk,
  input  logic               i_reset,
  // Register bus
  input  mcu_pkg::bus_addr_t i_bus_addr,
  input  mcu_pkg::word_t     i_bus_wdata,
  input  logic               i_bus_wr,
  input  logic               i_bus_rd,
  output mcu_pkg::word_t     o_bus_rdata,
  output logic               o_bus_rvalid,
  output mcu_pkg::irq_vec_t  o_irq,
  // Port 0 pads
  input  mcu_pkg::word_t     i_p0_pad_in,
  output mcu_pkg::word_t     o_p0_pad_out,
  output mcu_pkg::word_t     o_p0_pad_oe,
  // Port 1 pads
  input  mcu_pkg::word_t     i_p1_pad_in,
  output mcu_pkg::word_t     o_p1_pad_out,
  output mcu_pkg::word_t     o_p1_pad_oe
);

  logic [mcu_pkg::NUM_PERIPH-1:0] sel;
  mcu_pkg::word_t                 rdata [mcu_pkg::NUM_PERIPH];
  mcu_pkg::irq_vec_t              irq_lvl;

  // GPIO to pin mux
  mcu_pkg::word_t p0_dout;
  mcu_pkg::word_t p0_outen;
  mcu_pkg::word_t p1_dout;
  mcu_pkg::word_t p1_outen;
  mcu_pkg::word_t p1_altfunc;
  mcu_pkg::word_t p1_in;

  // Alternate-function signals
  logic [mcu_pkg::NUM_UART-1:0]  uart_txd;
  logic [mcu_pkg::NUM_UART-1:0]  uart_txen;
  logic [mcu_pkg::NUM_UART-1:0]  uart_rxd;
  logic [mcu_pkg::NUM_TIMER-1:0] timer_extin;

  periph_bus_if u_bus ();

  periph_ctrl u_ctrl (
    .i_hclk, .i_reset, .i_bus_addr, .i_bus_wdata, .i_bus_wr, .i_bus_rd,
    .o_bus_rdata, .o_bus_rvalid, .o_sel(sel), .i_rdata(rdata),
    .i_irq_lvl(irq_lvl), .o_irq, .bus(u_bus)
  );

  //------------------------------------------------------------------
  // GPIO ports
  //------------------------------------------------------------------
  gpio_port u_gpio0 (
    .i_hclk, .i_reset, .i_sel(sel[mcu_pkg::IDX_GPIO0]), .bus(u_bus),
    .o_rdata(rdata[mcu_pkg::IDX_GPIO0]), .i_pins(i_p0_pad_in),
    .o_dout(p0_dout), .o_outen(p0_outen), .o_altfunc()
  );

  gpio_port u_gpio1 (
    .i_hclk, .i_reset, .i_sel(sel[mcu_pkg::IDX_GPIO1]), .bus(u_bus),
    .o_rdata(rdata[mcu_pkg::IDX_GPIO1]), .i_pins(p1_in),
    .o_dout(p1_dout), .o_outen(p1_outen), .o_altfunc(p1_altfunc)
  );

  //------------------------------------------------------------------
  // UARTs and timers
  //------------------------------------------------------------------
  for (genvar k = 0; k < mcu_pkg::NUM_UART; k++) begin : g_uart
    uart u_uart (
      .i_hclk, .i_reset, .i_sel(sel[mcu_pkg::IDX_UART0+k]), .bus(u_bus),
      .o_rdata(rdata[mcu_pkg::IDX_UART0+k]), .i_rxd(uart_rxd[k]),
      .o_txd(uart_txd[k]), .o_txen(uart_txen[k]),
      .o_irq(irq_lvl[mcu_pkg::IRQ_UART0+k])
    );
  end

  for (genvar k = 0; k < mcu_pkg::NUM_TIMER; k++) begin : g_timer
    io_timer u_timer (
      .i_hclk, .i_reset, .i_sel(sel[mcu_pkg::IDX_TIMER0+k]), .bus(u_bus),
      .o_rdata(rdata[mcu_pkg::IDX_TIMER0+k]), .i_extin(timer_extin[k]),
      .o_irq(irq_lvl[mcu_pkg::IRQ_TIMER0+k])
    );
  end

  pin_mux u_pin_mux (
    .i_p0_dout(p0_dout), .i_p0_outen(p0_outen), .i_p1_dout(p1_dout),
    .i_p1_outen(p1_outen), .i_p1_altfunc(p1_altfunc), .i_pad_p1(i_p1_pad_in),
    .o_p0_pad_out, .o_p0_pad_oe, .o_p1_pad_out, .o_p1_pad_oe,
    .o_p1_in(p1_in), .i_uart_txd(uart_txd), .i_uart_txen(uart_txen),
    .o_uart_rxd(uart_rxd), .o_timer_extin(timer_extin)
  );

endmodule

//--- dv/tb_mcu_periph.sv
//----------------------------------------------------------------------
// MCU peripheral subsystem testbench
// Random register, pad, UART and timer traffic checked against a model
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mcu_periph;

  localparam int CLK_HALF   = 20;
  localparam int WAIT_LIMIT = 4000;

  logic               hclk;
  logic               reset;
  mcu_pkg::bus_addr_t bus_addr;
  mcu_pkg::word_t     bus_wdata;
  logic               bus_wr;
  logic               bus_rd;
  mcu_pkg::word_t     bus_rdata;
  logic               bus_rvalid;
  mcu_pkg::irq_vec_t  irq;
  mcu_pkg::word_t     p0_pad_in;
  mcu_pkg::word_t     p0_pad_out;
  mcu_pkg::word_t     p0_pad_oe;
  mcu_pkg::word_t     p1_pad_in;
  mcu_pkg::word_t     p1_pad_out;
  mcu_pkg::word_t     p1_pad_oe;

  // Reference model of the software-visible registers
  mcu_pkg::word_t m_dout [2];
  mcu_pkg::word_t m_outen [2];
  mcu_pkg::word_t m_altfunc [2];
  logic [1:0]     m_uart_ctrl [3];

  mcu_pkg::word_t rd_word;
  mcu_pkg::word_t wr_word;
  mcu_pkg::byte_t exp_byte;
  mcu_pkg::byte_t got_byte;
  mcu_pkg::reg_off_t off;
  logic           start_bit;
  logic           stop_bit;
  int             port;
  int             k;
  int             div;
  int             cycles;

  mcu_periph_top uut (
    .i_hclk(hclk), .i_reset(reset), .i_bus_addr(bus_addr), .i_bus_wdata(bus_wdata),
    .i_bus_wr(bus_wr), .i_bus_rd(bus_rd), .o_bus_rdata(bus_rdata),
    .o_bus_rvalid(bus_rvalid), .o_irq(irq),
    .i_p0_pad_in(p0_pad_in), .o_p0_pad_out(p0_pad_out), .o_p0_pad_oe(p0_pad_oe),
    .i_p1_pad_in(p1_pad_in), .o_p1_pad_out(p1_pad_out), .o_p1_pad_oe(p1_pad_oe)
  );

  initial hclk = 1'b0;
  always #(CLK_HALF) hclk = ~hclk;

  //--------------------------------------------------------------------
  // Failure reporting and compare tasks
  //--------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string what, input mcu_pkg::word_t got,
                            input mcu_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_byte(input string what, input mcu_pkg::byte_t got,
                            input mcu_pkg::byte_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_irq(input string what, input mcu_pkg::irq_vec_t got,
                           input mcu_pkg::irq_vec_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  //--------------------------------------------------------------------
  // Bus access, always entered on a falling edge
  //--------------------------------------------------------------------
  task automatic bus_write(input int idx, input mcu_pkg::reg_off_t roff,
                           input mcu_pkg::word_t data);
    bus_addr  = {3'(idx), 1'b0, roff};
    bus_wdata = data;
    bus_wr    = 1'b1;
    @(negedge hclk);
    bus_wr    = 1'b0;
  endtask

  task automatic bus_read(input int idx, input mcu_pkg::reg_off_t roff,
                          output mcu_pkg::word_t data);
    int waited;
    bus_addr = {3'(idx), 1'b0, roff};
    bus_rd   = 1'b1;
    @(negedge hclk);
    bus_rd   = 1'b0;
    waited   = 0;
    // Valid is due one cycle after the strobe
    while (bus_rvalid !== 1'b1) begin
      @(negedge hclk);
      waited++;
      if (waited > 8) begin
        $display("Timeout: read of peripheral %0d never returned a valid pulse", idx);
        stop_with_failure();
      end
    end
    check_word("read valid latency", mcu_pkg::word_t'(waited), 16'd0);
    data = bus_rdata;
  endtask

  task automatic wait_status_bit(input int idx, input int bit_pos, input logic level);
    mcu_pkg::word_t status;
    int polls;
    polls = 0;
    bus_read(idx, mcu_pkg::UART_STATUS, status);
    while (status[bit_pos] !== level) begin
      polls++;
      if (polls > WAIT_LIMIT) begin
        $display("Timeout: UART status bit %0d never reached %0b", bit_pos, level);
        stop_with_failure();
      end
      bus_read(idx, mcu_pkg::UART_STATUS, status);
    end
  endtask

  //--------------------------------------------------------------------
  // Expected pads from the model
  //--------------------------------------------------------------------
  // Idle UART lines drive a one on their alternate pin
  function automatic mcu_pkg::word_t exp_p1_out();
    mcu_pkg::word_t w;
    w = m_dout[1];
    for (int u = 0; u < 3; u++) begin
      if (m_altfunc[1][2*u+1]) w[2*u+1] = 1'b1;
    end
    return w;
  endfunction

  function automatic mcu_pkg::word_t exp_p1_oe();
    mcu_pkg::word_t w;
    w = m_outen[1];
    for (int u = 0; u < 3; u++) begin
      if (m_altfunc[1][2*u+1]) w[2*u+1] = m_uart_ctrl[u][0];
    end
    return w;
  endfunction

  task automatic check_pads();
    check_word("port 0 pad out", p0_pad_out, m_dout[0]);
    check_word("port 0 pad enable", p0_pad_oe, m_outen[0]);
    check_word("port 1 pad out", p1_pad_out, exp_p1_out());
    check_word("port 1 pad enable", p1_pad_oe, exp_p1_oe());
  endtask

  //--------------------------------------------------------------------
  // Behaviors
  //--------------------------------------------------------------------
  task automatic gpio_register_writes();
    for (int n = 0; n < 40; n++) begin
      port    = $urandom_range(1, 0);
      off     = mcu_pkg::reg_off_t'($urandom_range(3, 1));
      wr_word = mcu_pkg::word_t'($urandom());
      bus_write(port, off, wr_word);
      case (off)
        mcu_pkg::GPIO_DOUT:  m_dout[port]    = wr_word;
        mcu_pkg::GPIO_OUTEN: m_outen[port]   = wr_word;
        default:             m_altfunc[port] = wr_word;
      endcase
      bus_read(port, off, rd_word);
      check_word("GPIO register readback", rd_word, wr_word);
      // Now and then flip a UART transmit enable, receiver stays off
      if ($urandom_range(3, 0) == 0) begin
        k = $urandom_range(2, 0);
        m_uart_ctrl[k] = {1'b0, 1'($urandom_range(1, 0))};
        bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_CTRL, {14'd0, m_uart_ctrl[k]});
      end
      check_pads();
    end
  endtask

  task automatic pad_input_reads();
    for (int n = 0; n < 20; n++) begin
      p0_pad_in = mcu_pkg::word_t'($urandom());
      p1_pad_in = mcu_pkg::word_t'($urandom());
      repeat (3) @(negedge hclk);
      bus_read(mcu_pkg::IDX_GPIO0, mcu_pkg::GPIO_DATA, rd_word);
      check_word("port 0 GPIO_DATA", rd_word, p0_pad_in);
      bus_read(mcu_pkg::IDX_GPIO1, mcu_pkg::GPIO_DATA, rd_word);
      check_word("port 1 GPIO_DATA", rd_word, p1_pad_in);
    end
    p1_pad_in = 16'hffff;
    repeat (3) @(negedge hclk);
  endtask

  task automatic uart_transmit_frames();
    for (int n = 0; n < 6; n++) begin
      k        = $urandom_range(2, 0);
      div      = $urandom_range(20, 4);
      exp_byte = mcu_pkg::byte_t'($urandom());
      m_altfunc[1] = m_altfunc[1] | mcu_pkg::word_t'(1 << (2*k+1));
      bus_write(mcu_pkg::IDX_GPIO1, mcu_pkg::GPIO_ALTFUNC, m_altfunc[1]);
      bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_BAUDDIV, mcu_pkg::word_t'(div));
      m_uart_ctrl[k] = 2'b01;
      bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_CTRL, 16'h0001);
      check_pads();
      bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_DATA, {8'd0, exp_byte});
      cycles = 0;
      while (p1_pad_out[2*k+1] !== 1'b0) begin
        @(negedge hclk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          $display("Timeout: UART %0d never sent a start bit", k);
          stop_with_failure();
        end
      end
      // Middle of the start bit, then one bit period per sample
      repeat (div / 2) @(negedge hclk);
      start_bit = p1_pad_out[2*k+1];
      for (int i = 0; i < 8; i++) begin
        repeat (div) @(negedge hclk);
        got_byte[i] = p1_pad_out[2*k+1];
      end
      repeat (div) @(negedge hclk);
      stop_bit = p1_pad_out[2*k+1];
      check_byte("UART transmitted byte", got_byte, exp_byte);
      check_word("UART stop and start bits", {14'd0, stop_bit, start_bit}, 16'h0002);
      wait_status_bit(mcu_pkg::IDX_UART0 + k, 0, 1'b0);
      check_pads();
    end
  endtask

  task automatic uart_receive_frames();
    for (int n = 0; n < 6; n++) begin
      k        = $urandom_range(2, 0);
      div      = $urandom_range(20, 4);
      exp_byte = mcu_pkg::byte_t'($urandom());
      bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_BAUDDIV, mcu_pkg::word_t'(div));
      m_uart_ctrl[k] = 2'b10;
      bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_CTRL, 16'h0002);
      check_pads();
      // Start, eight data bits LSB first, stop
      p1_pad_in[2*k] = 1'b0;
      repeat (div) @(negedge hclk);
      for (int i = 0; i < 8; i++) begin
        p1_pad_in[2*k] = exp_byte[i];
        repeat (div) @(negedge hclk);
      end
      p1_pad_in[2*k] = 1'b1;
      repeat (div) @(negedge hclk);
      wait_status_bit(mcu_pkg::IDX_UART0 + k, 1, 1'b1);
      // Vector follows the flag by one cycle, already set when status shows full
      check_irq("UART receive interrupt", irq, mcu_pkg::irq_vec_t'(1 << k));
      bus_read(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_DATA, rd_word);
      check_byte("UART received byte", rd_word[7:0], exp_byte);
      // Flag drops at the read edge, vector one cycle later
      @(negedge hclk);
      check_irq("UART receive interrupt clear", irq, '0);
      bus_read(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_STATUS, rd_word);
      check_word("UART status after data read", rd_word, 16'h0000);
      m_uart_ctrl[k] = 2'b00;
      bus_write(mcu_pkg::IDX_UART0 + k, mcu_pkg::UART_CTRL, 16'h0000);
    end
  endtask

  task automatic timer_count_and_gate();
    for (int n = 0; n < 4; n++) begin
      k   = $urandom_range(1, 0);
      div = $urandom_range(40, 5);
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_RELOAD, mcu_pkg::word_t'(div));
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_VALUE, mcu_pkg::word_t'(div));
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_CTRL, 16'h0005);
      // Count to zero, reload with flag, then one cycle to o_irq
      cycles = 0;
      while (irq[mcu_pkg::IRQ_TIMER0 + k] !== 1'b1) begin
        @(negedge hclk);
        cycles++;
        if (cycles > div + WAIT_LIMIT) begin
          $display("Timeout: timer %0d never raised its interrupt", k);
          stop_with_failure();
        end
      end
      check_word("timer cycles to interrupt", mcu_pkg::word_t'(cycles),
                 mcu_pkg::word_t'(div + 2));
      check_irq("timer interrupt", irq, mcu_pkg::irq_vec_t'(1 << (3 + k)));
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_CTRL, 16'h0004);
      bus_read(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_INT, rd_word);
      check_word("timer flag", rd_word, 16'h0001);
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_INT, 16'h0001);
      // Flag clears at the write edge, vector one cycle later
      @(negedge hclk);
      check_irq("timer interrupt clear", irq, '0);

      // Gated count with the external pin held low
      p1_pad_in[8+k] = 1'b0;
      repeat (3) @(negedge hclk);
      wr_word = mcu_pkg::word_t'($urandom_range(1000, 100));
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_VALUE, wr_word);
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_CTRL, 16'h0003);
      repeat ($urandom_range(20, 5)) @(negedge hclk);
      bus_read(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_VALUE, rd_word);
      check_word("gated timer value", rd_word, wr_word);
      // Two sync stages, then one tick per cycle
      p1_pad_in[8+k] = 1'b1;
      repeat (10) @(negedge hclk);
      bus_read(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_VALUE, rd_word);
      check_word("released timer value", rd_word, wr_word - 16'd8);
      bus_write(mcu_pkg::IDX_TIMER0 + k, mcu_pkg::TMR_CTRL, 16'h0000);
      check_irq("interrupts after timer run", irq, '0);
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    void'($urandom(32'h59ae_cadd));
    reset     = 1'b1;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wr    = 1'b0;
    bus_rd    = 1'b0;
    p0_pad_in = '0;
    // UART receive lines idle high
    p1_pad_in = 16'hffff;
    for (int i = 0; i < 2; i++) begin
      m_dout[i]    = '0;
      m_outen[i]   = '0;
      m_altfunc[i] = '0;
    end
    for (int i = 0; i < 3; i++) m_uart_ctrl[i] = 2'b00;
    repeat (3) @(negedge hclk);
    reset = 1'b0;

    check_word("read valid after reset", {15'd0, bus_rvalid}, 16'd0);
    check_irq("interrupts after reset", irq, '0);
    check_pads();

    gpio_register_writes();
    pad_input_reads();
    uart_transmit_frames();
    uart_receive_frames();
    timer_count_and_gate();

    $display("** PASS **");
    $finish;
  end

endmodule

//--- filelist.f
common/mcu_pkg.sv
common/periph_bus_if.sv
rtl/periph_ctrl.sv
rtl/gpio_port.sv
uart/uart.sv
rtl/io_timer.sv
rtl/pin_mux.sv
rtl/mcu_periph_top.sv
dv/tb_mcu_periph.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MCU peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mcu_periph -Mdir obj_dir -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_mcu_periph
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
